/* rtl/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    // Datapath widths
    localparam int WORD_W     = 32;
    localparam int PHYS_REG_W = 6;
    localparam int ROB_PTR_W  = 5;

    // Load queue geometry
    localparam int LQ_DEPTH = 8;
    localparam int LQ_TAG_W = $clog2(LQ_DEPTH);

    // Load size encoding on the issue port
    localparam logic [1:0] LOAD_BYTE = 2'b00;
    localparam logic [1:0] LOAD_HALF = 2'b01;
    localparam logic [1:0] LOAD_WORD = 2'b10;

    // One cache response word, seen three ways
    typedef union packed {
        logic [WORD_W-1:0]  word;
        logic [1:0][15:0]   half;
        logic [3:0][7:0]    bytes;
    } mem_word_u;

endpackage

`default_nettype wire

/* rtl/lsu_agen.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_agen (
    input  logic                           clk_in,
    input  logic                           rst_N_in,
    input  logic                           flush,

    // Issue side
    input  logic                           insn_valid,
    output logic                           insn_ready,
    input  logic [lsu_pkg::WORD_W-1:0]     base,
    input  logic [lsu_pkg::WORD_W-1:0]     offset,
    input  logic [1:0]                     size,
    input  logic                           is_signed,
    input  logic [lsu_pkg::PHYS_REG_W-1:0] phys_dest,
    input  logic [lsu_pkg::ROB_PTR_W-1:0]  rob_ptr,

    // Toward the load queue
    output logic                           ag_valid,
    input  logic                           ag_ready,
    output logic [lsu_pkg::WORD_W-1:0]     ag_addr,
    output logic [1:0]                     ag_size,
    output logic                           ag_signed,
    output logic [lsu_pkg::PHYS_REG_W-1:0] ag_dest,
    output logic [lsu_pkg::ROB_PTR_W-1:0]  ag_rob_ptr
);

    logic accept;

    // Stage frees up in the same cycle the queue takes its load
    assign insn_ready = !ag_valid || ag_ready;
    assign accept     = insn_valid && insn_ready;

    always_ff @(posedge clk_in or negedge rst_N_in) begin
        if (!rst_N_in) begin
            ag_valid <= 1'b0;
        end else if (flush) begin
            ag_valid <= 1'b0;
        end else if (accept) begin
            ag_valid <= 1'b1;
        end else if (ag_ready) begin
            ag_valid <= 1'b0;
        end
    end

    // Effective address formed on acceptance
    always_ff @(posedge clk_in) begin
        if (accept) begin
            ag_addr    <= base + offset;
            ag_size    <= size;
            ag_signed  <= is_signed;
            ag_dest    <= phys_dest;
            ag_rob_ptr <= rob_ptr;
        end
    end

endmodule

`default_nettype wire

/* rtl/lsu_load_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_load_queue (
    input  logic                           clk_in,
    input  logic                           rst_N_in,
    input  logic                           flush,

    // From the address stage
    input  logic                           ag_valid,
    output logic                           ag_ready,
    input  logic [lsu_pkg::WORD_W-1:0]     ag_addr,
    input  logic [1:0]                     ag_size,
    input  logic                           ag_signed,
    input  logic [lsu_pkg::PHYS_REG_W-1:0] ag_dest,
    input  logic [lsu_pkg::ROB_PTR_W-1:0]  ag_rob_ptr,

    // Cache request
    output logic                           mem_req_valid,
    input  logic                           mem_req_ready,
    output logic [lsu_pkg::WORD_W-1:0]     mem_req_addr,
    output logic [lsu_pkg::LQ_TAG_W-1:0]   mem_req_tag,

    // Cache response
    input  logic                           mem_resp_valid,
    input  logic [lsu_pkg::LQ_TAG_W-1:0]   mem_resp_tag,
    input  logic [lsu_pkg::WORD_W-1:0]     mem_resp_data,

    // Matched response toward the align stage
    output logic                           hit_valid,
    output logic [lsu_pkg::WORD_W-1:0]     hit_data,
    output logic [1:0]                     hit_offset,
    output logic [1:0]                     hit_size,
    output logic                           hit_signed,
    output logic [lsu_pkg::PHYS_REG_W-1:0] hit_dest,
    output logic [lsu_pkg::ROB_PTR_W-1:0]  hit_rob_ptr
);

    import lsu_pkg::*;

    logic [LQ_DEPTH-1:0]   busy;
    logic [LQ_DEPTH-1:0]   squashed;
    logic [1:0]            ent_offset [LQ_DEPTH];
    logic [1:0]            ent_size   [LQ_DEPTH];
    logic                  ent_signed [LQ_DEPTH];
    logic [PHYS_REG_W-1:0] ent_dest   [LQ_DEPTH];
    logic [ROB_PTR_W-1:0]  ent_rob    [LQ_DEPTH];

    logic                  free_found;
    logic [LQ_TAG_W-1:0]   free_idx;
    logic                  stall_hold;
    logic [LQ_TAG_W-1:0]   stall_tag;
    logic                  alloc;

    // Lowest free slot wins
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = LQ_DEPTH - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_found = 1'b1;
                free_idx   = LQ_TAG_W'(i);
            end
        end
    end

    assign mem_req_valid = ag_valid && free_found;
    assign ag_ready      = free_found && mem_req_ready;
    assign mem_req_addr  = {ag_addr[WORD_W-1:2], 2'b00};
    // Tag must not move if a lower slot frees during a stall
    assign mem_req_tag   = stall_hold ? stall_tag : free_idx;
    assign alloc         = ag_valid && ag_ready;

    always_ff @(posedge clk_in or negedge rst_N_in) begin
        if (!rst_N_in) begin
            stall_hold <= 1'b0;
        end else begin
            stall_hold <= mem_req_valid && !mem_req_ready && !flush;
        end
    end

    always_ff @(posedge clk_in) begin
        stall_tag <= mem_req_tag;
    end

    always_ff @(posedge clk_in or negedge rst_N_in) begin
        if (!rst_N_in) begin
            busy     <= '0;
            squashed <= '0;
        end else begin
            for (int i = 0; i < LQ_DEPTH; i++) begin
                if (alloc && mem_req_tag == LQ_TAG_W'(i)) begin
                    busy[i]     <= 1'b1;
                    squashed[i] <= flush;
                end else if (mem_resp_valid && mem_resp_tag == LQ_TAG_W'(i)) begin
                    busy[i]     <= 1'b0;
                    squashed[i] <= 1'b0;
                end else if (flush && busy[i]) begin
                    squashed[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (alloc) begin
            ent_offset[mem_req_tag] <= ag_addr[1:0];
            ent_size[mem_req_tag]   <= ag_size;
            ent_signed[mem_req_tag] <= ag_signed;
            ent_dest[mem_req_tag]   <= ag_dest;
            ent_rob[mem_req_tag]    <= ag_rob_ptr;
        end
    end

    // Squashed responses only release their slot
    assign hit_valid   = mem_resp_valid && busy[mem_resp_tag] && !squashed[mem_resp_tag];
    assign hit_data    = mem_resp_data;
    assign hit_offset  = ent_offset[mem_resp_tag];
    assign hit_size    = ent_size[mem_resp_tag];
    assign hit_signed  = ent_signed[mem_resp_tag];
    assign hit_dest    = ent_dest[mem_resp_tag];
    assign hit_rob_ptr = ent_rob[mem_resp_tag];

endmodule

`default_nettype wire

/* rtl/lsu_align.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_align (
    input  logic                           clk_in,
    input  logic                           rst_N_in,

    // Matched response from the load queue
    input  logic                           hit_valid,
    input  logic [lsu_pkg::WORD_W-1:0]     hit_data,
    input  logic [1:0]                     hit_offset,
    input  logic [1:0]                     hit_size,
    input  logic                           hit_signed,
    input  logic [lsu_pkg::PHYS_REG_W-1:0] hit_dest,
    input  logic [lsu_pkg::ROB_PTR_W-1:0]  hit_rob_ptr,

    // Register file write port
    output logic                           rf_wr_en,
    output logic [lsu_pkg::PHYS_REG_W-1:0] rf_wr_idx,
    output logic [lsu_pkg::WORD_W-1:0]     rf_wr_data,

    // Completion to the reorder buffer
    output logic                           wb_valid,
    output logic [lsu_pkg::ROB_PTR_W-1:0]  wb_rob_ptr
);

    import lsu_pkg::*;

    mem_word_u         resp;
    logic [7:0]        sel_byte;
    logic [15:0]       sel_half;
    logic [WORD_W-1:0] load_val;
    logic              done_q;

    assign resp     = hit_data;
    assign sel_byte = resp.bytes[hit_offset];
    // Halfword ignores address bit 0
    assign sel_half = resp.half[hit_offset[1]];

    always_comb begin
        case (hit_size)
            LOAD_BYTE: load_val = {{(WORD_W-8){hit_signed & sel_byte[7]}}, sel_byte};
            LOAD_HALF: load_val = {{(WORD_W-16){hit_signed & sel_half[15]}}, sel_half};
            default:   load_val = resp.word;
        endcase
    end

    always_ff @(posedge clk_in or negedge rst_N_in) begin
        if (!rst_N_in) begin
            done_q <= 1'b0;
        end else begin
            done_q <= hit_valid;
        end
    end

    always_ff @(posedge clk_in) begin
        if (hit_valid) begin
            rf_wr_idx  <= hit_dest;
            rf_wr_data <= load_val;
            wb_rob_ptr <= hit_rob_ptr;
        end
    end

    // Register write and completion leave together
    assign rf_wr_en = done_q;
    assign wb_valid = done_q;

endmodule

`default_nettype wire

/* rtl/lsu_load_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_load_pipe (
    input  logic                           clk_in,
    input  logic                           rst_N_in,
    input  logic                           flush,

    // Issue
    input  logic                           insn_valid,
    output logic                           insn_ready,
    input  logic [lsu_pkg::WORD_W-1:0]     base,
    input  logic [lsu_pkg::WORD_W-1:0]     offset,
    input  logic [1:0]                     size,
    input  logic                           is_signed,
    input  logic [lsu_pkg::PHYS_REG_W-1:0] phys_dest,
    input  logic [lsu_pkg::ROB_PTR_W-1:0]  rob_ptr,

    // Data cache
    output logic                           mem_req_valid,
    input  logic                           mem_req_ready,
    output logic [lsu_pkg::WORD_W-1:0]     mem_req_addr,
    output logic [lsu_pkg::LQ_TAG_W-1:0]   mem_req_tag,
    input  logic                           mem_resp_valid,
    input  logic [lsu_pkg::LQ_TAG_W-1:0]   mem_resp_tag,
    input  logic [lsu_pkg::WORD_W-1:0]     mem_resp_data,

    // Register file and reorder buffer
    output logic                           rf_wr_en,
    output logic [lsu_pkg::PHYS_REG_W-1:0] rf_wr_idx,
    output logic [lsu_pkg::WORD_W-1:0]     rf_wr_data,
    output logic                           wb_valid,
    output logic [lsu_pkg::ROB_PTR_W-1:0]  wb_rob_ptr
);

    import lsu_pkg::*;

    logic                  ag_valid;
    logic                  ag_ready;
    logic [WORD_W-1:0]     ag_addr;
    logic [1:0]            ag_size;
    logic                  ag_signed;
    logic [PHYS_REG_W-1:0] ag_dest;
    logic [ROB_PTR_W-1:0]  ag_rob_ptr;

    logic                  hit_valid;
    logic [WORD_W-1:0]     hit_data;
    logic [1:0]            hit_offset;
    logic [1:0]            hit_size;
    logic                  hit_signed;
    logic [PHYS_REG_W-1:0] hit_dest;
    logic [ROB_PTR_W-1:0]  hit_rob_ptr;

    lsu_agen agen_inst (
        .clk_in, .rst_N_in, .flush,
        .insn_valid, .insn_ready, .base, .offset, .size, .is_signed, .phys_dest, .rob_ptr,
        .ag_valid, .ag_ready, .ag_addr, .ag_size, .ag_signed, .ag_dest, .ag_rob_ptr
    );

    lsu_load_queue load_queue_inst (
        .clk_in, .rst_N_in, .flush,
        .ag_valid, .ag_ready, .ag_addr, .ag_size, .ag_signed, .ag_dest, .ag_rob_ptr,
        .mem_req_valid, .mem_req_ready, .mem_req_addr, .mem_req_tag,
        .mem_resp_valid, .mem_resp_tag, .mem_resp_data,
        .hit_valid, .hit_data, .hit_offset, .hit_size, .hit_signed, .hit_dest, .hit_rob_ptr
    );

    lsu_align align_inst (
        .clk_in, .rst_N_in,
        .hit_valid, .hit_data, .hit_offset, .hit_size, .hit_signed, .hit_dest, .hit_rob_ptr,
        .rf_wr_en, .rf_wr_idx, .rf_wr_data, .wb_valid, .wb_rob_ptr
    );

endmodule

`default_nettype wire

/* bench/lsu_load_pipe_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_load_pipe_chk (
    input  logic                         clk_in,
    input  logic                         rst_N_in,
    input  logic                         flush,
    input  logic                         insn_ready,
    input  logic                         mem_req_valid,
    input  logic                         mem_req_ready,
    input  logic [lsu_pkg::WORD_W-1:0]   mem_req_addr,
    input  logic [lsu_pkg::LQ_TAG_W-1:0] mem_req_tag,
    input  logic                         rf_wr_en,
    input  logic                         wb_valid
);

    // A stalled request holds until the cache takes it
    property req_stable_p;
        @(posedge clk_in) disable iff (!rst_N_in)
        mem_req_valid && !mem_req_ready && !flush |=>
            mem_req_valid && $stable(mem_req_addr) && $stable(mem_req_tag);
    endproperty

    property wr_matches_wb_p;
        @(posedge clk_in) rf_wr_en == wb_valid;
    endproperty

    property idle_in_reset_p;
        @(posedge clk_in)
        !rst_N_in |-> !mem_req_valid && !rf_wr_en && !wb_valid && insn_ready;
    endproperty

    req_stable_a: assert property (req_stable_p)
        else $error("cache request changed while stalled");

    wr_matches_wb_a: assert property (wr_matches_wb_p)
        else $error("register write and writeback disagree");

    idle_in_reset_a: assert property (idle_in_reset_p)
        else $error("output active during reset");

endmodule

bind lsu_load_pipe lsu_load_pipe_chk lsu_load_pipe_chk_inst (.*);

`default_nettype wire

/* bench/lsu_load_pipe_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_load_pipe_tb;

    import lsu_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int NUM_LOADS    = 400;
    localparam int WORST_CYCLES = 40;

    logic                  clk_in;
    logic                  rst_N_in;
    logic                  flush;
    logic                  insn_valid;
    logic                  insn_ready;
    logic [WORD_W-1:0]     base;
    logic [WORD_W-1:0]     offset;
    logic [1:0]            size;
    logic                  is_signed;
    logic [PHYS_REG_W-1:0] phys_dest;
    logic [ROB_PTR_W-1:0]  rob_ptr;
    logic                  mem_req_valid;
    logic                  mem_req_ready;
    logic [WORD_W-1:0]     mem_req_addr;
    logic [LQ_TAG_W-1:0]   mem_req_tag;
    logic                  mem_resp_valid;
    logic [LQ_TAG_W-1:0]   mem_resp_tag;
    logic [WORD_W-1:0]     mem_resp_data;
    logic                  rf_wr_en;
    logic [PHYS_REG_W-1:0] rf_wr_idx;
    logic [WORD_W-1:0]     rf_wr_data;
    logic                  wb_valid;
    logic [ROB_PTR_W-1:0]  wb_rob_ptr;

    integer seed = 32'hacf310c6;
    int     errors;
    int     issued;
    int     wb_checked;
    logic   accepted;
    logic [ROB_PTR_W-1:0] next_rob;

    // Scoreboard indexed by rob_ptr
    logic                  sb_valid [1 << ROB_PTR_W];
    logic [WORD_W-1:0]     sb_addr  [1 << ROB_PTR_W];
    logic [WORD_W-1:0]     sb_data  [1 << ROB_PTR_W];
    logic [PHYS_REG_W-1:0] sb_dest  [1 << ROB_PTR_W];
    int                    sb_count;

    // Bench view of the address stage and the queue tags
    logic                 agen_full;
    logic [ROB_PTR_W-1:0] agen_rob;
    logic                 tag_busy [LQ_DEPTH];
    logic                 tag_live [LQ_DEPTH];
    logic [ROB_PTR_W-1:0] tag_rob  [LQ_DEPTH];
    logic                 due_valid;
    logic [ROB_PTR_W-1:0] due_rob;

    // Cache model requests still waiting for a response
    logic [LQ_TAG_W-1:0] pend_tag  [$];
    logic [WORD_W-1:0]   pend_addr [$];

    lsu_load_pipe lsu_load_pipe_inst (.*);

    always #(CLK_PERIOD / 2) clk_in = ~clk_in;

    function automatic logic [WORD_W-1:0] mem_word_at(input logic [WORD_W-1:0] addr);
        logic [WORD_W-1:0] a;
        a = {addr[WORD_W-1:2], 2'b00};
        return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a0f0f;
    endfunction

    function automatic logic [WORD_W-1:0] expected_load(input logic [WORD_W-1:0] addr,
                                                        input logic [1:0] sz,
                                                        input logic sgn);
        mem_word_u w;
        logic [7:0] b;
        logic [15:0] h;
        w.word = mem_word_at(addr);
        b = w.bytes[addr[1:0]];
        h = w.half[addr[1]];
        if (sz == LOAD_BYTE)
            return {{24{sgn & b[7]}}, b};
        else if (sz == LOAD_HALF)
            return {{16{sgn & h[15]}}, h};
        return w.word;
    endfunction

    function automatic int urand(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic check_value(input string name, input logic [WORD_W-1:0] exp,
                               input logic [WORD_W-1:0] act);
        assert (exp === act) else begin
            errors++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_idle_outputs();
        check_value("reset_req_valid", 0, WORD_W'(mem_req_valid));
        check_value("reset_rf_wr_en", 0, WORD_W'(rf_wr_en));
        check_value("reset_wb_valid", 0, WORD_W'(wb_valid));
        check_value("reset_insn_ready", 1, WORD_W'(insn_ready));
    endtask

    // Called at the falling edge, models what the next rising edge does
    task automatic observe_cycle();
        int t;
        logic free_slot;
        // Issue may stall only when the address stage is full and cannot drain
        free_slot = 1'b0;
        for (int i = 0; i < LQ_DEPTH; i++) begin
            if (!tag_busy[i])
                free_slot = 1'b1;
        end
        check_value("insn_ready", WORD_W'(!agen_full || (free_slot && mem_req_ready)),
                    WORD_W'(insn_ready));
        if (due_valid) begin
            assert (wb_valid) else begin
                errors++;
                $display("no writeback one cycle after the response for rob %0d", due_rob);
            end
            if (wb_valid) begin
                check_value("writeback_rob", WORD_W'(due_rob), WORD_W'(wb_rob_ptr));
                check_value("writeback_dest", WORD_W'(sb_dest[due_rob]), WORD_W'(rf_wr_idx));
                check_value("writeback_data", sb_data[due_rob], rf_wr_data);
                wb_checked++;
            end
            sb_valid[due_rob] = 1'b0;
            sb_count--;
            due_valid = 1'b0;
        end else begin
            assert (!wb_valid) else begin
                errors++;
                $display("writeback for rob %0d that no live response asked for", wb_rob_ptr);
            end
        end
        // A slot freed by this cycle's response is still busy for this request
        if (mem_req_valid && mem_req_ready) begin
            t = int'(mem_req_tag);
            assert (!tag_busy[t]) else begin
                errors++;
                $display("request tag %0d names an entry that is still busy", t);
            end
            assert (agen_full) else begin
                errors++;
                $display("cache request without a load in the address stage");
            end
            check_value("request_addr", {sb_addr[agen_rob][WORD_W-1:2], 2'b00}, mem_req_addr);
            tag_busy[t] = 1'b1;
            tag_live[t] = 1'b1;
            tag_rob[t]  = agen_rob;
            pend_tag.push_back(mem_req_tag);
            pend_addr.push_back(mem_req_addr);
            agen_full = 1'b0;
        end
        if (mem_resp_valid) begin
            t = int'(mem_resp_tag);
            if (tag_live[t]) begin
                due_valid = 1'b1;
                due_rob   = tag_rob[t];
            end
            tag_busy[t] = 1'b0;
            tag_live[t] = 1'b0;
        end
        if (flush) begin
            for (int i = 0; i < LQ_DEPTH; i++) begin
                if (tag_busy[i] && tag_live[i]) begin
                    sb_valid[tag_rob[i]] = 1'b0;
                    sb_count--;
                    tag_live[i] = 1'b0;
                end
            end
            if (agen_full) begin
                sb_valid[agen_rob] = 1'b0;
                sb_count--;
                agen_full = 1'b0;
            end
        end
        if (insn_valid && insn_ready) begin
            accepted = 1'b1;
            if (!flush) begin
                sb_valid[rob_ptr] = 1'b1;
                sb_addr[rob_ptr]  = base + offset;
                sb_data[rob_ptr]  = expected_load(base + offset, size, is_signed);
                sb_dest[rob_ptr]  = phys_dest;
                sb_count++;
                agen_full = 1'b1;
                agen_rob  = rob_ptr;
            end
        end
    endtask

    // Called 1 ns after the rising edge
    task automatic drive_cycle();
        int phase;
        int idx;
        logic [7:0] r;
        phase = (issued / 100) % 4;
        flush = (issued > 20) && (urand(48) == 0);
        if (!insn_valid || accepted) begin
            accepted = 1'b0;
            // Like a ROB, never hand out a pointer whose load is still in flight
            if (issued < NUM_LOADS && !sb_valid[next_rob] && urand(4) != 0) begin
                r          = 8'($random(seed));
                insn_valid = 1'b1;
                base       = $random(seed);
                offset     = {{24{r[7]}}, r};
                size       = 2'(urand(3));
                is_signed  = 1'($random(seed));
                phys_dest  = PHYS_REG_W'($random(seed));
                rob_ptr    = next_rob;
                next_rob   = next_rob + 1'b1;
                issued++;
            end else begin
                insn_valid = 1'b0;
            end
        end
        // Phase 1 fills the queue, phase 2 stalls requests
        mem_req_ready = (phase == 2) ? (urand(4) == 0) : (urand(4) != 0);
        mem_resp_valid = 1'b0;
        if (pend_tag.size() > 0 && urand(phase == 1 ? 10 : 2) == 0) begin
            idx            = urand(pend_tag.size());
            mem_resp_valid = 1'b1;
            mem_resp_tag   = pend_tag[idx];
            mem_resp_data  = mem_word_at(pend_addr[idx]);
            pend_tag.delete(idx);
            pend_addr.delete(idx);
        end
    endtask

    initial begin
        #(NUM_LOADS * WORST_CYCLES * CLK_PERIOD);
        $display("timeout: the loads did not all complete in time");
        $display("Something failed");
        $finish;
    end

    initial begin
        clk_in = 1'b0;
        rst_N_in = 1'b0;
        flush = 1'b0;
        insn_valid = 1'b0;
        base = '0;
        offset = '0;
        size = LOAD_WORD;
        is_signed = 1'b0;
        phys_dest = '0;
        rob_ptr = '0;
        mem_req_ready = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_tag = '0;
        mem_resp_data = '0;
        errors = 0;
        issued = 0;
        wb_checked = 0;
        accepted = 1'b0;
        next_rob = '0;
        sb_count = 0;
        agen_full = 1'b0;
        due_valid = 1'b0;
        for (int i = 0; i < (1 << ROB_PTR_W); i++)
            sb_valid[i] = 1'b0;
        for (int i = 0; i < LQ_DEPTH; i++) begin
            tag_busy[i] = 1'b0;
            tag_live[i] = 1'b0;
        end
        repeat (5) begin
            @(negedge clk_in);
            check_idle_outputs();
        end
        @(posedge clk_in);
        #1 rst_N_in = 1'b1;
        @(negedge clk_in);
        check_idle_outputs();
        while (issued < NUM_LOADS || insn_valid || agen_full || sb_count > 0
               || due_valid || pend_tag.size() > 0) begin
            @(posedge clk_in);
            #1;
            drive_cycle();
            @(negedge clk_in);
            observe_cycle();
        end
        repeat (3) @(posedge clk_in);
        $display("summary: %0d errors, %0d loads issued, %0d writebacks checked",
                 errors, issued, wb_checked);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* lsu_load_pipe.f */
rtl/lsu_pkg.sv
rtl/lsu_agen.sv
rtl/lsu_load_queue.sv
rtl/lsu_align.sv
rtl/lsu_load_pipe.sv
bench/lsu_load_pipe_chk.sv
bench/lsu_load_pipe_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= lsu_load_pipe_tb
FLIST     ?= lsu_load_pipe.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FLIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
